/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/mem_bus_pkg.sv
      - design/dcache_arrays.sv
      - design/dcache_ctrl.sv
      - design/victim_writer.sv
      - design/line_filler.sv
      - design/mem_arbiter.sv
      - design/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_assertions.sv
      - verification/dcache_tb.sv

/* design/dcache_arrays.sv */
`timescale 1ns/1ns

module dcache_arrays import dcache_pkg::*; #(
    parameter int SETS = dcache_pkg::SETS,
    parameter int WAYS = dcache_pkg::WAYS
) (
    input  logic                clk,
    input  logic                rst,
    input  index_t              rd_index_i,
    input  logic [WAYS-1:0]     wr_way_i,
    input  index_t              wr_index_i,
    input  logic [LINE_W/8-1:0] wr_bytes_i,
    input  line_t               wr_line_i,
    input  tag_t                wr_tag_i,
    input  logic                wr_dirty_i,
    input  logic                lru_we_i,
    input  logic                lru_i,
    output tag_t  [WAYS-1:0]    tag_o,
    output logic  [WAYS-1:0]    valid_o,
    output line_t [WAYS-1:0]    line_o,
    output logic  [WAYS-1:0]    dirty_o,
    output logic                lru_o
);

    localparam int BYTES = LINE_W / 8;

    if (WAYS != 2) begin : g_check_ways
        $error("dcache_arrays holds exactly two ways, WAYS = %0d", WAYS);
    end

    tag_t            tag_mem  [WAYS][SETS];
    line_t           data_mem [WAYS][SETS];
    logic [SETS-1:0] valid_q  [WAYS];
    logic [SETS-1:0] dirty_q  [WAYS];
    logic [SETS-1:0] lru_q;     // 1: way 1 goes next

    logic  same_set;
    line_t rd_line [WAYS];

    assign same_set = (rd_index_i == wr_index_i);

    //////////////////////////////////////////////////
    // tag and data storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_way_i[w]) begin
                tag_mem[w][wr_index_i] <= wr_tag_i;
                for (int b = 0; b < BYTES; b++) begin
                    if (wr_bytes_i[b])
                        data_mem[w][wr_index_i][8*b +: 8] <= wr_line_i[8*b +: 8];
                end
            end
        end
    end

    // collision bypass, written bytes win
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_line[w] = data_mem[w][rd_index_i];
            if (wr_way_i[w] && same_set) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (wr_bytes_i[b])
                        rd_line[w][8*b +: 8] = wr_line_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            line_o[w] <= rd_line[w];
            tag_o[w]  <= (wr_way_i[w] && same_set) ? wr_tag_i : tag_mem[w][rd_index_i];
        end
    end

    //////////////////////////////////////////////////
    // valid, dirty and lru bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (wr_way_i[w]) begin
                    valid_q[w][wr_index_i] <= 1'b1;
                    dirty_q[w][wr_index_i] <= wr_dirty_i;
                end
            end
            if (lru_we_i)
                lru_q[wr_index_i] <= lru_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= '0;
            dirty_o <= '0;
            lru_o   <= 1'b0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                valid_o[w] <= (wr_way_i[w] && same_set) || valid_q[w][rd_index_i];
                dirty_o[w] <= (wr_way_i[w] && same_set) ? wr_dirty_i : dirty_q[w][rd_index_i];
            end
            lru_o <= (lru_we_i && same_set) ? lru_i : lru_q[rd_index_i];
        end
    end

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*, mem_bus_pkg::*; #(
    parameter int SETS = dcache_pkg::SETS,
    parameter int WAYS = dcache_pkg::WAYS
) (
    input  logic                clk,
    input  logic                rst,
    // cpu side
    input  logic                req_i,
    input  logic                we_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [WORD_W/8-1:0] wsel_i,
    input  word_t               wdata_i,
    output logic                stall_o,
    output logic                data_ok_o,
    output word_t               rdata_o,
    // arrays
    output index_t              rd_index_o,
    output logic [WAYS-1:0]     wr_way_o,
    output index_t              wr_index_o,
    output logic [LINE_W/8-1:0] wr_bytes_o,
    output line_t               wr_line_o,
    output tag_t                wr_tag_o,
    output logic                wr_dirty_o,
    output logic                lru_we_o,
    output logic                lru_o,
    input  tag_t  [WAYS-1:0]    tag_i,
    input  logic  [WAYS-1:0]    valid_i,
    input  line_t [WAYS-1:0]    line_i,
    input  logic  [WAYS-1:0]    dirty_i,
    input  logic                lru_i,
    // miss engines
    output logic                wb_start_o,
    output logic [ADDR_W-1:0]   wb_addr_o,
    output line_t               wb_line_o,
    output logic                fill_start_o,
    output logic [ADDR_W-1:0]   fill_addr_o,
    input  logic                fill_done_i,
    input  line_t               fill_line_i
);

    localparam int IDX_BITS = $clog2(SETS);
    localparam int WSEL_W = WORD_W / 8;
    localparam int WOFF_W = $clog2(WORDS_PER_LINE);
    localparam int BYTES = LINE_W / 8;

    miss_state_t state;

    logic              s2_valid;
    logic              s2_we;
    logic [ADDR_W-1:0] s2_addr;
    logic [WSEL_W-1:0] s2_wsel;
    word_t             s2_wdata;
    tag_t              s2_tag;
    index_t            s2_index;
    logic [WOFF_W-1:0] s2_woff;

    logic [WAYS-1:0] hit_way;
    logic            hit;
    logic            hit_sel;
    logic            miss;
    logic            victim;
    line_t           fill_merged;
    word_t           hit_word;
    word_t           fill_word;

    function automatic index_t addr_index(input logic [ADDR_W-1:0] a);
        return index_t'(a[OFFSET_W +: IDX_BITS]);
    endfunction

    //////////////////////////////////////////////////
    // stage 2 request, held while stalled
    always_ff @(posedge clk) begin
        if (!rst)
            s2_valid <= 1'b0;
        else if (!stall_o)
            s2_valid <= req_i;
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            s2_we    <= we_i;
            s2_addr  <= addr_i;
            s2_wsel  <= wsel_i;
            s2_wdata <= wdata_i;
        end
    end

    assign s2_tag   = tag_t'(s2_addr >> (OFFSET_W + IDX_BITS));
    assign s2_index = addr_index(s2_addr);
    assign s2_woff  = s2_addr[OFFSET_W-1 -: WOFF_W];

    // keep reading the stalled set
    assign rd_index_o = stall_o ? s2_index : addr_index(addr_i);

    //////////////////////////////////////////////////
    // lookup
    always_comb begin
        for (int w = 0; w < WAYS; w++)
            hit_way[w] = valid_i[w] && (tag_i[w] == s2_tag);
    end

    assign hit     = |hit_way;
    assign hit_sel = hit_way[1];
    assign miss    = s2_valid && !hit;
    assign victim  = lru_i;     // lru names the way to replace

    assign hit_word  = line_i[hit_sel][s2_woff*WORD_W +: WORD_W];
    assign fill_word = fill_merged[s2_woff*WORD_W +: WORD_W];

    // store data over the returned line
    always_comb begin
        fill_merged = fill_line_i;
        if (s2_we) begin
            for (int b = 0; b < WSEL_W; b++) begin
                if (s2_wsel[b])
                    fill_merged[s2_woff*WORD_W + 8*b +: 8] = s2_wdata[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // miss fsm
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (miss) state <= MISS_WAIT;
                MISS_WAIT: if (fill_done_i) state <= FILL_WRITE;
                default:   state <= IDLE;
            endcase
        end
    end

    assign fill_start_o = (state == IDLE) && miss;
    assign wb_start_o   = fill_start_o && valid_i[victim] && dirty_i[victim];
    assign wb_addr_o    = (ADDR_W'(tag_i[victim]) << (OFFSET_W + IDX_BITS))
                        | (ADDR_W'(s2_index) << OFFSET_W);
    assign wb_line_o    = line_i[victim];
    assign fill_addr_o  = {s2_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // array writes, hit store or refill
    assign wr_index_o = s2_index;
    assign wr_tag_o   = s2_tag;

    always_comb begin
        wr_way_o   = '0;
        wr_bytes_o = '0;
        wr_line_o  = {WORDS_PER_LINE{s2_wdata}};
        wr_dirty_o = 1'b1;
        lru_we_o   = 1'b0;
        lru_o      = !hit_sel;
        if (state == IDLE && s2_valid && hit) begin
            lru_we_o = 1'b1;
            if (s2_we) begin
                wr_way_o[hit_sel] = 1'b1;
                wr_bytes_o        = BYTES'(s2_wsel) << (s2_woff * WSEL_W);
            end
        end else if (state == FILL_WRITE) begin
            wr_way_o[victim] = 1'b1;
            wr_bytes_o       = '1;
            wr_line_o        = fill_merged;
            wr_dirty_o       = s2_we;   // a write miss leaves the line dirty
            lru_we_o         = 1'b1;
            lru_o            = !victim;
        end
    end

    // cpu outputs
    assign stall_o   = (state == MISS_WAIT) || (state == IDLE && miss);
    assign data_ok_o = s2_valid && !s2_we && ((state == IDLE && hit) || state == FILL_WRITE);
    assign rdata_o   = (state == FILL_WRITE) ? fill_word : hit_word;

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // address and word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // line geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W = WORD_W * WORDS_PER_LINE;
    localparam int SETS = 256;
    localparam int INDEX_W = $clog2(SETS);
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAYS = 2;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [LINE_W-1:0]  line_t;

endpackage

/* design/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*, mem_bus_pkg::*; #(
    parameter int SETS = dcache_pkg::SETS,
    parameter int WAYS = dcache_pkg::WAYS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic [WORD_W/8-1:0]   wsel_i,
    input  word_t                 wdata_i,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output word_t                 rdata_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [ADDR_W-1:0]     mem_addr_o,
    output logic [MEM_DATA_W-1:0] mem_wdata_o,
    input  logic                  mem_ack_i,
    input  logic [MEM_DATA_W-1:0] mem_rdata_i
);

    index_t              rd_index;
    logic [WAYS-1:0]     wr_way;
    index_t              wr_index;
    logic [LINE_W/8-1:0] wr_bytes;
    line_t               wr_line;
    tag_t                wr_tag;
    logic                wr_dirty;
    logic                lru_we;
    logic                lru_new;
    tag_t  [WAYS-1:0]    way_tag;
    logic  [WAYS-1:0]    way_valid;
    line_t [WAYS-1:0]    way_line;
    logic  [WAYS-1:0]    way_dirty;
    logic                lru_cur;

    logic              wb_start;
    logic [ADDR_W-1:0] wb_addr;
    line_t             wb_line;
    logic              wb_req;
    logic [ADDR_W-1:0] wb_mem_addr;
    line_t             wb_mem_line;
    logic              wb_ack;
    logic              fill_start;
    logic [ADDR_W-1:0] fill_addr;
    logic              fill_req;
    logic [ADDR_W-1:0] fill_mem_addr;
    logic              fill_ack;
    logic              fill_done;
    line_t             fill_line;

    dcache_ctrl #(.SETS(SETS), .WAYS(WAYS)) u_ctrl (
        .clk(clk), .rst(rst),
        .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wsel_i(wsel_i), .wdata_i(wdata_i),
        .stall_o(stall_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
        .rd_index_o(rd_index), .wr_way_o(wr_way), .wr_index_o(wr_index),
        .wr_bytes_o(wr_bytes), .wr_line_o(wr_line), .wr_tag_o(wr_tag),
        .wr_dirty_o(wr_dirty), .lru_we_o(lru_we), .lru_o(lru_new),
        .tag_i(way_tag), .valid_i(way_valid), .line_i(way_line),
        .dirty_i(way_dirty), .lru_i(lru_cur),
        .wb_start_o(wb_start), .wb_addr_o(wb_addr), .wb_line_o(wb_line),
        .fill_start_o(fill_start), .fill_addr_o(fill_addr),
        .fill_done_i(fill_done), .fill_line_i(fill_line)
    );

    dcache_arrays #(.SETS(SETS), .WAYS(WAYS)) u_arrays (
        .clk(clk), .rst(rst),
        .rd_index_i(rd_index), .wr_way_i(wr_way), .wr_index_i(wr_index),
        .wr_bytes_i(wr_bytes), .wr_line_i(wr_line), .wr_tag_i(wr_tag),
        .wr_dirty_i(wr_dirty), .lru_we_i(lru_we), .lru_i(lru_new),
        .tag_o(way_tag), .valid_o(way_valid), .line_o(way_line),
        .dirty_o(way_dirty), .lru_o(lru_cur)
    );

    victim_writer u_victim (
        .clk(clk), .rst(rst), .start_i(wb_start), .addr_i(wb_addr), .line_i(wb_line),
        .req_o(wb_req), .addr_o(wb_mem_addr), .line_o(wb_mem_line), .ack_i(wb_ack)
    );

    line_filler u_filler (
        .clk(clk), .rst(rst), .start_i(fill_start), .addr_i(fill_addr),
        .req_o(fill_req), .addr_o(fill_mem_addr), .ack_i(fill_ack),
        .rdata_i(mem_rdata_i), .done_o(fill_done), .line_o(fill_line)
    );

    // write-back wins the port ahead of the refill
    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .wb_req_i(wb_req), .wb_addr_i(wb_mem_addr), .wb_line_i(wb_mem_line), .wb_ack_o(wb_ack),
        .fill_req_i(fill_req), .fill_addr_i(fill_mem_addr), .fill_ack_o(fill_ack),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i)
    );

endmodule

/* design/line_filler.sv */
`timescale 1ns/1ns

module line_filler import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  logic [ADDR_W-1:0]     addr_i,
    output logic                  req_o,
    output logic [ADDR_W-1:0]     addr_o,
    input  logic                  ack_i,
    input  logic [MEM_DATA_W-1:0] rdata_i,
    output logic                  done_o,
    output line_t                 line_o
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            req_o  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= req_o && ack_i;
            if (start_i)
                req_o <= 1'b1;
            else if (ack_i)
                req_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i)
            addr_o <= addr_i;
        if (req_o && ack_i)
            line_o <= rdata_i;  // data valid only in the ack cycle
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // victim writer
    input  logic                  wb_req_i,
    input  logic [ADDR_W-1:0]     wb_addr_i,
    input  line_t                 wb_line_i,
    output logic                  wb_ack_o,
    // line filler
    input  logic                  fill_req_i,
    input  logic [ADDR_W-1:0]     fill_addr_i,
    output logic                  fill_ack_o,
    // memory port
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [ADDR_W-1:0]     mem_addr_o,
    output logic [MEM_DATA_W-1:0] mem_wdata_o,
    input  logic                  mem_ack_i
);

    logic fill_lock;    // fill owns the port until its ack
    logic wb_grant;
    logic fill_grant;

    assign fill_grant = fill_lock || (fill_req_i && !wb_req_i);
    assign wb_grant   = !fill_lock && wb_req_i;

    always_ff @(posedge clk) begin
        if (!rst)
            fill_lock <= 1'b0;
        else
            fill_lock <= fill_grant && fill_req_i && !mem_ack_i;
    end

    assign mem_req_o   = wb_grant || (fill_grant && fill_req_i);
    assign mem_we_o    = wb_grant;
    assign mem_addr_o  = wb_grant ? wb_addr_i : fill_addr_i;
    assign mem_wdata_o = wb_line_i;

    assign wb_ack_o   = wb_grant && mem_ack_i;
    assign fill_ack_o = fill_grant && mem_ack_i;

endmodule

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one whole line per memory transfer
    localparam int MEM_DATA_W = dcache_pkg::LINE_W;

    // miss handling in the controller
    typedef enum logic [1:0] {
        IDLE,
        MISS_WAIT,
        FILL_WRITE
    } miss_state_t;

endpackage

/* design/victim_writer.sv */
`timescale 1ns/1ns

module victim_writer import dcache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  line_t             line_i,
    output logic              req_o,
    output logic [ADDR_W-1:0] addr_o,
    output line_t             line_o,
    input  logic              ack_i
);

    always_ff @(posedge clk) begin
        if (!rst)
            req_o <= 1'b0;
        else if (start_i)
            req_o <= 1'b1;
        else if (ack_i)
            req_o <= 1'b0;     // line is in memory
    end

    // victim copy, the array may be refilled meanwhile
    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_o <= addr_i;
            line_o <= line_i;
        end
    end

endmodule

/* flist.f */
design/dcache_pkg.sv
design/mem_bus_pkg.sv
design/dcache_arrays.sv
design/dcache_ctrl.sv
design/victim_writer.sv
design/line_filler.sv
design/mem_arbiter.sv
design/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

/* verification/dcache_assertions.sv */
`timescale 1ns/1ns

module dcache_assertions import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_o,
    input  logic              data_ok_o,
    input  logic              mem_req_o,
    input  logic              mem_we_o,
    input  logic [ADDR_W-1:0] mem_addr_o,
    input  line_t             mem_wdata_o,
    input  logic              mem_ack_i,
    input  miss_state_t       state_i
);

    int failures = 0;   // read by the testbench at the end

    // request fields hold until the ack
    a_mem_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else begin
            failures++;
            $error("memory request changed before its ack");
        end

    a_ok_not_stalled: assert property (@(posedge clk) disable iff (!rst)
        !(data_ok_o && stall_o))
        else begin
            failures++;
            $error("data_ok_o raised while stall_o is high");
        end

    // control outputs quiet right after a reset edge
    a_reset_quiet: assert property (@(posedge clk)
        !rst |=> !stall_o && !data_ok_o && !mem_req_o && state_i == IDLE)
        else begin
            failures++;
            $error("control outputs not low after reset");
        end

endmodule

bind dcache_top dcache_assertions u_props (
    .clk(clk), .rst(rst), .stall_o(stall_o), .data_ok_o(data_ok_o),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i), .state_i(u_ctrl.state)
);

/* verification/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb import dcache_pkg::*; ();

    localparam int WAIT_LIMIT = 100;
    localparam logic [31:0] FILL_KEY = 32'h3c5a_96e1;

    logic              clk = 1'b0;
    logic              rst;
    logic              req_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [3:0]        wsel_i;
    word_t             wdata_i;
    logic              stall_o;
    logic              data_ok_o;
    word_t             rdata_o;
    logic              mem_req_o;
    logic              mem_we_o;
    logic [ADDR_W-1:0] mem_addr_o;
    line_t             mem_wdata_o;
    logic              mem_ack_i = 1'b0;
    line_t             mem_rdata_i = '0;

    integer seed = 32'h2ddf484a;
    integer mem_rnd;
    integer stim_rnd;
    int     errors = 0;
    int     timeouts = 0;

    // memory contents and transaction log
    line_t             mem_lines [logic [31:0]];
    logic              mem_busy = 1'b0;
    logic [1:0]        mem_wait = '0;
    logic              log_we   [$];
    logic [31:0]       log_addr [$];
    line_t             log_data [$];

    // shadow of the cache state and of the data seen by the cpu
    word_t             shadow   [logic [29:0]];
    tag_t              sh_tag   [2][SETS];
    logic              sh_valid [2][SETS];
    logic              sh_dirty [2][SETS];
    logic              sh_lru   [SETS];

    dcache_top #(.SETS(SETS), .WAYS(WAYS)) dut0 (
        .clk(clk), .rst(rst),
        .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wsel_i(wsel_i), .wdata_i(wdata_i),
        .stall_o(stall_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

    always #5 clk = ~clk;

    function automatic word_t init_word(input logic [31:0] a);
        return {2'b00, a[31:2]} ^ FILL_KEY;
    endfunction

    function automatic line_t mem_line(input logic [31:0] laddr);
        line_t l;
        if (mem_lines.exists(laddr))
            return mem_lines[laddr];
        for (int i = 0; i < WORDS_PER_LINE; i++)
            l[i*WORD_W +: WORD_W] = init_word(laddr + 32'(4 * i));
        return l;
    endfunction

    function automatic word_t shadow_word(input logic [31:0] a);
        return shadow.exists(a[31:2]) ? shadow[a[31:2]] : init_word(a);
    endfunction

    function automatic line_t expected_line(input logic [31:0] laddr);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++)
            l[i*WORD_W +: WORD_W] = shadow_word(laddr + 32'(4 * i));
        return l;
    endfunction

    //////////////////////////////////////////////////
    // memory model, acks after 1 to 4 cycles
    always @(posedge clk) begin
        if (!rst) begin
            mem_ack_i <= 1'b0;
            mem_busy  <= 1'b0;
        end else begin
            mem_ack_i <= 1'b0;
            if (mem_busy) begin
                if (mem_wait == 2'd0) begin
                    mem_ack_i <= 1'b1;
                    mem_busy  <= 1'b0;
                    log_we.push_back(mem_we_o);
                    log_addr.push_back(mem_addr_o);
                    log_data.push_back(mem_wdata_o);
                    if (mem_we_o)
                        mem_lines[mem_addr_o] = mem_wdata_o;
                    else
                        mem_rdata_i <= mem_line(mem_addr_o);
                end else begin
                    mem_wait <= mem_wait - 2'd1;
                end
            end else if (mem_req_o && !mem_ack_i) begin
                mem_rnd  = $random(seed);
                mem_busy <= 1'b1;
                mem_wait <= mem_rnd[1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // checks and end of run
    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        int total;
        total = errors + timeouts + dut0.u_props.failures;
        $display("errors: checks %0d, timeouts %0d, assertions %0d",
                 errors, timeouts, dut0.u_props.failures);
        if (total == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    // transactions of one access, write-back before refill
    task automatic compare_transactions(input string name, input int n0, input logic miss,
                                        input logic [31:0] fill_addr, input logic exp_wb,
                                        input logic [31:0] wb_addr, input line_t wb_data);
        int n;
        int k;
        n = log_we.size() - n0;
        k = n0;
        check_value({name, " transactions"}, 128'(int'(miss) + int'(exp_wb)), 128'(n));
        if (n == int'(miss) + int'(exp_wb)) begin
            if (exp_wb) begin
                check_value({name, " wb we"}, 128'(1), 128'(log_we[k]));
                check_value({name, " wb addr"}, 128'(wb_addr), 128'(log_addr[k]));
                check_value({name, " wb data"}, wb_data, log_data[k]);
                k++;
            end
            if (miss) begin
                check_value({name, " fill we"}, 128'(0), 128'(log_we[k]));
                check_value({name, " fill addr"}, 128'(fill_addr), 128'(log_addr[k]));
            end
        end
    endtask

    task automatic access(input string name, input logic we, input logic [31:0] addr,
                          input logic [3:0] wsel, input word_t wdata);
        tag_t        tag;
        index_t      idx;
        int          hit_w;
        int          v;
        int          n0;
        int          cycles;
        logic        exp_wb;
        logic [31:0] wb_addr;
        line_t       wb_data;
        word_t       exp_word;
        tag = addr[ADDR_W-1 -: TAG_W];
        idx = addr[OFFSET_W +: INDEX_W];
        hit_w = -1;
        exp_wb = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int w = 0; w < 2; w++)
            if (sh_valid[w][idx] && sh_tag[w][idx] == tag)
                hit_w = w;
        if (hit_w >= 0) begin
            sh_lru[idx] = (hit_w == 0);     // point at the other way
            if (we)
                sh_dirty[hit_w][idx] = 1'b1;
        end else begin
            v = int'(sh_lru[idx]);
            if (sh_valid[v][idx] && sh_dirty[v][idx]) begin
                exp_wb  = 1'b1;
                wb_addr = {sh_tag[v][idx], idx, {OFFSET_W{1'b0}}};
                wb_data = expected_line(wb_addr);
            end
            sh_tag[v][idx]   = tag;
            sh_valid[v][idx] = 1'b1;
            sh_dirty[v][idx] = we;
            sh_lru[idx]      = (v == 0);
        end
        exp_word = shadow_word(addr);
        if (we) begin
            for (int b = 0; b < 4; b++)
                if (wsel[b])
                    exp_word[8*b +: 8] = wdata[8*b +: 8];
            shadow[addr[31:2]] = exp_word;
        end
        n0 = log_we.size();

        @(posedge clk);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wsel_i  <= wsel;
        wdata_i <= wdata;
        @(posedge clk);
        req_i <= 1'b0;      // accepted at this edge
        @(negedge clk);
        cycles = 0;
        while (stall_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall_o) begin
            $display("timeout: %s still stalled after %0d cycles", name, WAIT_LIMIT);
            timeouts++;
            finish_run();
        end else begin
            check_value({name, " data_ok"}, 128'(!we), 128'(data_ok_o));
            if (!we)
                check_value({name, " rdata"}, 128'(exp_word), 128'(rdata_o));
            compare_transactions(name, n0, hit_w < 0, {addr[31:OFFSET_W], {OFFSET_W{1'b0}}},
                                 exp_wb, wb_addr, wb_data);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    initial begin
        rst     = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wsel_i  = '0;
        wdata_i = '0;
        for (int s = 0; s < SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                sh_tag[w][s]   = '0;
                sh_valid[w][s] = 1'b0;
                sh_dirty[w][s] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("reset stall", '0, 128'(stall_o));
        check_value("reset data_ok", '0, 128'(data_ok_o));
        check_value("reset mem_req", '0, 128'(mem_req_o));

        access("read cold", 1'b0, 32'h0000_1234, 4'h0, '0);
        access("read again", 1'b0, 32'h0000_1234, 4'h0, '0);
        access("write hit", 1'b1, 32'h0000_1234, 4'b0110, 32'hdead_beef);
        access("read merged", 1'b0, 32'h0000_1234, 4'h0, '0);
        access("write miss", 1'b1, 32'h0000_5678, 4'b1001, 32'hcafe_f00d);
        access("read write miss", 1'b0, 32'h0000_5678, 4'h0, '0);

        // three tags in set 0x40, the first one dirty
        access("evict tag 1", 1'b1, 32'h0001_0408, 4'hf, 32'h1234_5678);
        access("evict tag 2", 1'b0, 32'h0002_0408, 4'h0, '0);
        access("evict tag 3", 1'b0, 32'h0003_0408, 4'h0, '0);
        access("reread tag 1", 1'b0, 32'h0001_0408, 4'h0, '0);

        // mixed traffic over two sets and four tags
        for (int i = 0; i < 24; i++) begin
            stim_rnd = $random(seed);
            access($sformatf("random %0d", i), stim_rnd[5],
                   {18'h0, stim_rnd[1:0], 7'h40, stim_rnd[2], stim_rnd[4:3], 2'b00},
                   stim_rnd[9:6], $random(seed));
        end
        finish_run();
    end

endmodule
